//--- rx_pcs_defines.svh
`ifndef RX_PCS_DEFINES_SVH
`define RX_PCS_DEFINES_SVH

// Lane and block geometry
`define RX_LANES    4
`define BLK_W       64
`define HDR_W       2
`define CTL_W       8

// Sync headers
`define HDR_DATA    2'b01
`define HDR_CTRL    2'b10

// Block type field of control blocks
`define BT_IDLE     8'h1E
`define BT_START    8'h78
`define BT_T0       8'h87
`define BT_T1       8'h99
`define BT_T2       8'hAA
`define BT_T3       8'hB4
`define BT_T4       8'hCC
`define BT_T5       8'hD2
`define BT_T6       8'hE1
`define BT_T7       8'hFF

// XGMII control characters
`define XG_IDLE     8'h07
`define XG_START    8'hFB
`define XG_TERM     8'hFD
`define XG_ERROR    8'hFE

// x^58 + x^39 + 1, taps as bits back in the serial history
`define SCR_TAP_A   38
`define SCR_TAP_B   57

// APB register map
`define ADDR_CTRL   8'h00
`define ADDR_ERRCNT 8'h04
`define ERRCNT_W    8

`endif

//--- rx_pcs_pkg.sv
`default_nettype none

`include "rx_pcs_defines.svh"

package rx_pcs_pkg;

    // Control block layout, type byte sent first
    typedef struct packed {
        logic [`BLK_W-9:0] content;
        logic [7:0]        btype;
    } ctrl_blk_t;

    // One payload word, seen as data bytes or as a control block
    typedef union packed {
        logic [`BLK_W/8-1:0][7:0] bytes;
        ctrl_blk_t                ctrl;
    } blk_payload_u;

    //////////////////////////////
    // Per-word lane bundles
    //////////////////////////////

    typedef logic [`RX_LANES-1:0][`BLK_W-1:0] lane_data_t;

    typedef logic [`RX_LANES-1:0][`HDR_W-1:0] lane_hdr_t;

    typedef logic [`RX_LANES-1:0][`CTL_W-1:0] lane_ctl_t;

endpackage

`default_nettype wire

//--- lane_reorder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_pcs_defines.svh"

module lane_reorder (
    input  wire                         rx_clk_161_13,
    input  wire                         async_reset_n,
    input  wire                         rx_valid_i,
    input  wire rx_pcs_pkg::lane_hdr_t  rx_hdr_i,
    input  wire rx_pcs_pkg::lane_data_t rx_data_i,
    input  wire [1:0]                   lane_rot_i,
    output logic                        valid_o,
    output rx_pcs_pkg::lane_hdr_t       hdr_o,
    output rx_pcs_pkg::lane_data_t      data_o
);

    rx_pcs_pkg::lane_hdr_t  rot_hdr;
    rx_pcs_pkg::lane_data_t rot_data;

    // Output lane i takes input lane (i + rot) mod lanes
    always_comb begin
        for (int i = 0; i < `RX_LANES; i++) begin
            rot_hdr[i]  = rx_hdr_i[(i + int'(lane_rot_i)) % `RX_LANES];
            rot_data[i] = rx_data_i[(i + int'(lane_rot_i)) % `RX_LANES];
        end
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= rx_valid_i;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (rx_valid_i) begin
            hdr_o  <= rot_hdr;
            data_o <= rot_data;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Downstream stages rely on clean words whenever valid is up
    a_known_when_valid: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        valid_o |-> !$isunknown({hdr_o, data_o})
    );

endmodule

`default_nettype wire

//--- lane_descrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_pcs_defines.svh"

module lane_descrambler (
    input  wire                         rx_clk_161_13,
    input  wire                         async_reset_n,
    input  wire                         valid_i,
    input  wire rx_pcs_pkg::lane_hdr_t  hdr_i,
    input  wire rx_pcs_pkg::lane_data_t data_i,
    input  wire                         bypass_descram_i,
    output logic                        valid_o,
    output rx_pcs_pkg::lane_hdr_t       hdr_o,
    output rx_pcs_pkg::lane_data_t      data_o
);

    localparam int STREAM_W = (`RX_LANES + 1) * `BLK_W;
    localparam int DLY_A    = `SCR_TAP_A + 1;
    localparam int DLY_B    = `SCR_TAP_B + 1;

    // Raw last lane of the previous valid word
    logic [`BLK_W-1:0]      prev_raw;
    logic [STREAM_W-1:0]    stream;
    rx_pcs_pkg::lane_data_t plain;

    // Serial order, oldest bit at index 0
    assign stream = {data_i, prev_raw};

    //////////////////////////////
    // Parallel descrambler
    //////////////////////////////

    always_comb begin
        for (int k = 0; k < `RX_LANES; k++) begin
            for (int j = 0; j < `BLK_W; j++) begin
                plain[k][j] = stream[`BLK_W * (k + 1) + j]
                            ^ stream[`BLK_W * (k + 1) + j - DLY_A]
                            ^ stream[`BLK_W * (k + 1) + j - DLY_B];
            end
        end
    end

    // History moves on valid words only, bypass or not
    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o  <= 1'b0;
            prev_raw <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                prev_raw <= data_i[`RX_LANES-1];
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (valid_i) begin
            hdr_o <= hdr_i;
            if (bypass_descram_i) begin
                data_o <= data_i;
            end else begin
                data_o <= plain;
            end
        end
    end

endmodule

`default_nettype wire

//--- block_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_pcs_defines.svh"

module block_decoder (
    input  wire                         rx_clk_161_13,
    input  wire                         async_reset_n,
    input  wire                         valid_i,
    input  wire rx_pcs_pkg::lane_hdr_t  hdr_i,
    input  wire rx_pcs_pkg::lane_data_t data_i,
    output logic                        rx_valid_o,
    output rx_pcs_pkg::lane_ctl_t       xgmii_rxc_o,
    output rx_pcs_pkg::lane_data_t      xgmii_rxd_o,
    output logic [2:0]                  blk_err_cnt_o
);

    rx_pcs_pkg::lane_ctl_t  rxc_d;
    rx_pcs_pkg::lane_data_t rxd_d;
    logic [`RX_LANES-1:0]   blk_err;
    logic [2:0]             err_cnt;

    //////////////////////////////
    // Per-lane decode
    //////////////////////////////

    always_comb begin
        rx_pcs_pkg::blk_payload_u blk;
        logic [7:0][7:0]          shifted;
        logic [2:0]               tlen;
        logic                     is_term;
        logic                     term_seen;

        term_seen = 1'b0;
        for (int k = 0; k < `RX_LANES; k++) begin
            blk     = data_i[k];
            // Payload bytes 1..7 moved down to byte 0
            shifted = {8'h00, blk.ctrl.content};
            is_term = blk.ctrl.btype inside {`BT_T0, `BT_T1, `BT_T2, `BT_T3,
                                             `BT_T4, `BT_T5, `BT_T6, `BT_T7};
            case (blk.ctrl.btype)
                `BT_T1:  tlen = 3'd1;
                `BT_T2:  tlen = 3'd2;
                `BT_T3:  tlen = 3'd3;
                `BT_T4:  tlen = 3'd4;
                `BT_T5:  tlen = 3'd5;
                `BT_T6:  tlen = 3'd6;
                `BT_T7:  tlen = 3'd7;
                default: tlen = 3'd0;
            endcase

            // Error block unless a rule below matches
            rxc_d[k]   = '1;
            rxd_d[k]   = {8{`XG_ERROR}};
            blk_err[k] = 1'b1;

            if (hdr_i[k] == `HDR_DATA) begin
                if (!term_seen) begin
                    rxc_d[k]   = '0;
                    rxd_d[k]   = blk.bytes;
                    blk_err[k] = 1'b0;
                end
            end else if (hdr_i[k] == `HDR_CTRL) begin
                if (blk.ctrl.btype == `BT_IDLE) begin
                    rxd_d[k]   = {8{`XG_IDLE}};
                    blk_err[k] = 1'b0;
                end else if (blk.ctrl.btype == `BT_START) begin
                    rxc_d[k]   = 8'h01;
                    rxd_d[k]   = {blk.ctrl.content, `XG_START};
                    blk_err[k] = 1'b0;
                end else if (is_term && !term_seen) begin
                    for (int m = 0; m < 8; m++) begin
                        if (m < tlen) begin
                            rxc_d[k][m]         = 1'b0;
                            rxd_d[k][8*m +: 8]  = shifted[m];
                        end else if (m == tlen) begin
                            rxd_d[k][8*m +: 8]  = `XG_TERM;
                        end else begin
                            rxd_d[k][8*m +: 8]  = `XG_IDLE;
                        end
                    end
                    blk_err[k] = 1'b0;
                end
            end

            // Marks every higher lane of this word
            term_seen = term_seen | ((hdr_i[k] == `HDR_CTRL) && is_term);
        end
    end

    always_comb begin
        err_cnt = 3'd0;
        for (int k = 0; k < `RX_LANES; k++) begin
            err_cnt = err_cnt + {2'b00, blk_err[k]};
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            rx_valid_o    <= 1'b0;
            xgmii_rxc_o   <= '0;
            xgmii_rxd_o   <= '0;
            blk_err_cnt_o <= 3'd0;
        end else begin
            rx_valid_o    <= valid_i;
            blk_err_cnt_o <= valid_i ? err_cnt : 3'd0;
            if (valid_i) begin
                xgmii_rxc_o <= rxc_d;
                xgmii_rxd_o <= rxd_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- rx_pcs_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_pcs_defines.svh"

module rx_pcs_regs (
    input  wire          rx_clk_161_13,
    input  wire          async_reset_n,
    input  wire          psel_i,
    input  wire          penable_i,
    input  wire          pwrite_i,
    input  wire [7:0]    paddr_i,
    input  wire [31:0]   pwdata_i,
    input  wire [2:0]    blk_err_cnt_i,
    output logic [31:0]  prdata_o,
    output logic         pready_o,
    output logic         pslverr_o,
    output logic [1:0]   lane_rot_o,
    output logic         bypass_descram_o
);

    logic                 access;
    logic                 addr_ok;
    logic                 wr_ctrl;
    logic                 wr_errcnt;
    logic [`ERRCNT_W-1:0] err_cnt;
    logic [`ERRCNT_W:0]   err_sum;

    // Zero wait states
    assign access    = psel_i & penable_i;
    assign addr_ok   = (paddr_i == `ADDR_CTRL) || (paddr_i == `ADDR_ERRCNT);
    assign pready_o  = access;
    assign pslverr_o = access & ~addr_ok;

    assign wr_ctrl   = access & pwrite_i & (paddr_i == `ADDR_CTRL);
    assign wr_errcnt = access & pwrite_i & (paddr_i == `ADDR_ERRCNT);

    always_comb begin
        prdata_o = 32'd0;
        if (access && !pwrite_i) begin
            if (paddr_i == `ADDR_CTRL) begin
                prdata_o = {29'd0, lane_rot_o, bypass_descram_o};
            end else if (paddr_i == `ADDR_ERRCNT) begin
                prdata_o = {{(32-`ERRCNT_W){1'b0}}, err_cnt};
            end
        end
    end

    //////////////////////////////
    // CTRL and error counter
    //////////////////////////////

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            bypass_descram_o <= 1'b0;
            lane_rot_o       <= 2'd0;
        end else if (wr_ctrl) begin
            bypass_descram_o <= pwdata_i[0];
            lane_rot_o       <= pwdata_i[2:1];
        end
    end

    assign err_sum = {1'b0, err_cnt} + {{(`ERRCNT_W-2){1'b0}}, blk_err_cnt_i};

    // Clear wins over increment, count sticks at all ones
    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            err_cnt <= '0;
        end else if (wr_errcnt) begin
            err_cnt <= '0;
        end else if (err_sum[`ERRCNT_W]) begin
            err_cnt <= '1;
        end else begin
            err_cnt <= err_sum[`ERRCNT_W-1:0];
        end
    end

    a_penable_in_transfer: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        $rose(penable_i) |-> psel_i
    );

endmodule

`default_nettype wire

//--- rx_pcs_top.sv
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_top (
    input  wire                         rx_clk_161_13,
    input  wire                         async_reset_n,
    // APB
    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire [7:0]                   paddr_i,
    input  wire [31:0]                  pwdata_i,
    output wire [31:0]                  prdata_o,
    output wire                         pready_o,
    output wire                         pslverr_o,
    // Received blocks
    input  wire                         rx_valid_i,
    input  wire rx_pcs_pkg::lane_hdr_t  rx_hdr_i,
    input  wire rx_pcs_pkg::lane_data_t rx_data_i,
    // XGMII side
    output wire                         rx_valid_o,
    output wire rx_pcs_pkg::lane_ctl_t  xgmii_rxc_o,
    output wire rx_pcs_pkg::lane_data_t xgmii_rxd_o
);

    wire [1:0]                   lane_rot;
    wire                         bypass_descram;
    wire [2:0]                   blk_err_cnt;

    wire                         reo_valid;
    wire rx_pcs_pkg::lane_hdr_t  reo_hdr;
    wire rx_pcs_pkg::lane_data_t reo_data;

    wire                         dsc_valid;
    wire rx_pcs_pkg::lane_hdr_t  dsc_hdr;
    wire rx_pcs_pkg::lane_data_t dsc_data;

    rx_pcs_regs u_rx_pcs_regs (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .blk_err_cnt_i    (blk_err_cnt),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .lane_rot_o       (lane_rot),
        .bypass_descram_o (bypass_descram)
    );

    //////////////////////////////
    // Three stage data path
    //////////////////////////////

    lane_reorder u_lane_reorder (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .rx_valid_i    (rx_valid_i),
        .rx_hdr_i      (rx_hdr_i),
        .rx_data_i     (rx_data_i),
        .lane_rot_i    (lane_rot),
        .valid_o       (reo_valid),
        .hdr_o         (reo_hdr),
        .data_o        (reo_data)
    );

    lane_descrambler u_lane_descrambler (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .valid_i          (reo_valid),
        .hdr_i            (reo_hdr),
        .data_i           (reo_data),
        .bypass_descram_i (bypass_descram),
        .valid_o          (dsc_valid),
        .hdr_o            (dsc_hdr),
        .data_o           (dsc_data)
    );

    block_decoder u_block_decoder (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .valid_i       (dsc_valid),
        .hdr_i         (dsc_hdr),
        .data_i        (dsc_data),
        .rx_valid_o    (rx_valid_o),
        .xgmii_rxc_o   (xgmii_rxc_o),
        .xgmii_rxd_o   (xgmii_rxd_o),
        .blk_err_cnt_o (blk_err_cnt)
    );

endmodule

`default_nettype wire

//--- tb_rx_pcs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_pcs_defines.svh"

module tb_rx_pcs;

    // About 900 cycles of stimulus
    localparam int CYCLE_LIMIT = 3000;

    logic                   rx_clk_161_13;
    logic                   async_reset_n;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [7:0]             paddr_i;
    logic [31:0]            pwdata_i;
    wire  [31:0]            prdata_o;
    wire                    pready_o;
    wire                    pslverr_o;
    logic                   rx_valid_i;
    rx_pcs_pkg::lane_hdr_t  rx_hdr_i;
    rx_pcs_pkg::lane_data_t rx_data_i;
    wire                    rx_valid_o;
    rx_pcs_pkg::lane_ctl_t  xgmii_rxc_o;
    rx_pcs_pkg::lane_data_t xgmii_rxd_o;

    // Reference model state
    logic [57:0]            scr_hist;
    int                     rot;
    logic                   scr_on;
    int                     model_errcnt;
    int                     fails;
    int                     tests;
    int                     cycle_cnt;
    logic                   exp_valid;
    rx_pcs_pkg::lane_ctl_t  exp_rxc;
    rx_pcs_pkg::lane_data_t exp_rxd;
    logic                   exp_slverr;
    logic [31:0]            exp_rdata;
    logic [2:0]             pipe_valid;
    rx_pcs_pkg::lane_ctl_t  pipe_rxc [3];
    rx_pcs_pkg::lane_data_t pipe_rxd [3];

    rx_pcs_top u_rx_pcs_top (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .rx_valid_i    (rx_valid_i),
        .rx_hdr_i      (rx_hdr_i),
        .rx_data_i     (rx_data_i),
        .rx_valid_o    (rx_valid_o),
        .xgmii_rxc_o   (xgmii_rxc_o),
        .xgmii_rxd_o   (xgmii_rxd_o)
    );

    initial begin
        rx_clk_161_13 = 1'b0;
        forever #50 rx_clk_161_13 = ~rx_clk_161_13;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge rx_clk_161_13);
            cycle_cnt++;
        end
        $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////
    // Expected word delay line
    //////////////////////////////

    always @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            pipe_valid <= 3'b000;
        end else begin
            pipe_valid <= {pipe_valid[1:0], exp_valid};
        end
    end

    always @(posedge rx_clk_161_13) begin
        pipe_rxc[0] <= exp_rxc;
        pipe_rxd[0] <= exp_rxd;
        pipe_rxc[1] <= pipe_rxc[0];
        pipe_rxd[1] <= pipe_rxd[0];
        pipe_rxc[2] <= pipe_rxc[1];
        pipe_rxd[2] <= pipe_rxd[1];
    end

    // Outputs are stable at the falling edge
    a_rx_valid: assert property (@(negedge rx_clk_161_13) disable iff (!async_reset_n)
        rx_valid_o == pipe_valid[2])
    else begin
        $display("Error at %0t: rx_valid_o is %b, expected %b", $time, rx_valid_o, pipe_valid[2]);
        fails++;
    end

    a_xgmii_word: assert property (@(negedge rx_clk_161_13) disable iff (!async_reset_n)
        pipe_valid[2] |-> (xgmii_rxc_o == pipe_rxc[2] && xgmii_rxd_o == pipe_rxd[2]))
    else begin
        $display("Error at %0t: XGMII word rxc %h rxd %h, expected rxc %h rxd %h", $time,
                 xgmii_rxc_o, xgmii_rxd_o, pipe_rxc[2], pipe_rxd[2]);
        fails++;
    end

    a_apb_resp: assert property (@(negedge rx_clk_161_13) disable iff (!async_reset_n)
        (psel_i && penable_i) |-> (pready_o && pslverr_o == exp_slverr))
    else begin
        $display("Error at %0t: APB pready %b pslverr %b at address %h", $time,
                 pready_o, pslverr_o, paddr_i);
        fails++;
    end

    a_apb_rdata: assert property (@(negedge rx_clk_161_13) disable iff (!async_reset_n)
        (psel_i && penable_i && !pwrite_i && !exp_slverr) |-> prdata_o == exp_rdata)
    else begin
        $display("Error at %0t: read %h from address %h, expected %h", $time,
                 prdata_o, paddr_i, exp_rdata);
        fails++;
    end

    //////////////////////////////
    // Block rules
    //////////////////////////////

    function automatic logic [7:0] term_code(input int n);
        case (n)
            0:       return `BT_T0;
            1:       return `BT_T1;
            2:       return `BT_T2;
            3:       return `BT_T3;
            4:       return `BT_T4;
            5:       return `BT_T5;
            6:       return `BT_T6;
            7:       return `BT_T7;
            default: return 8'h00;
        endcase
    endfunction

    // Data bytes of a terminate or -1 for other types
    function automatic int term_len(input logic [7:0] btype);
        for (int n = 0; n < 8; n++) begin
            if (term_code(n) == btype) begin
                return n;
            end
        end
        return -1;
    endfunction

    task automatic decode_word(
        input  rx_pcs_pkg::lane_hdr_t  h,
        input  rx_pcs_pkg::lane_data_t p,
        output rx_pcs_pkg::lane_ctl_t  c,
        output rx_pcs_pkg::lane_data_t x,
        output int                     nerr
    );
        logic [7:0]  btype;
        logic [63:0] tail;
        logic        after_term;
        logic        bad;
        int          tl;
        after_term = 1'b0;
        nerr = 0;
        for (int k = 0; k < `RX_LANES; k++) begin
            btype = p[k][7:0];
            tail  = p[k] >> 8;
            tl    = term_len(btype);
            c[k]  = 8'hFF;
            x[k]  = {8{`XG_ERROR}};
            bad   = 1'b1;
            if (h[k] == `HDR_DATA && !after_term) begin
                c[k] = 8'h00;
                x[k] = p[k];
                bad  = 1'b0;
            end else if (h[k] == `HDR_CTRL && btype == `BT_IDLE) begin
                x[k] = {8{`XG_IDLE}};
                bad  = 1'b0;
            end else if (h[k] == `HDR_CTRL && btype == `BT_START) begin
                c[k] = 8'h01;
                x[k] = {p[k][63:8], `XG_START};
                bad  = 1'b0;
            end else if (h[k] == `HDR_CTRL && tl >= 0 && !after_term) begin
                for (int m = 0; m < 8; m++) begin
                    c[k][m]        = (m >= tl);
                    x[k][8*m +: 8] = (m < tl) ? tail[8*m +: 8] :
                                     (m == tl) ? `XG_TERM : `XG_IDLE;
                end
                bad = 1'b0;
            end
            if (h[k] == `HDR_CTRL && tl >= 0) begin
                after_term = 1'b1;
            end
            if (bad) begin
                nerr++;
            end
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic step();
        @(posedge rx_clk_161_13);
        #5;
    endtask

    task automatic send_gap();
        step();
        rx_valid_i = 1'b0;
        rx_hdr_i   = 8'($urandom);
        rx_data_i  = {$urandom, $urandom, $urandom, $urandom,
                      $urandom, $urandom, $urandom, $urandom};
        exp_valid  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) send_gap();
    endtask

    // Scramble serially in output lane order and undo the rotation
    task automatic send_word(input rx_pcs_pkg::lane_hdr_t h, input rx_pcs_pkg::lane_data_t p);
        rx_pcs_pkg::lane_ctl_t  c;
        rx_pcs_pkg::lane_data_t x;
        rx_pcs_pkg::lane_data_t raw;
        int                     nerr;
        logic                   bit_s;
        decode_word(h, p, c, x, nerr);
        for (int k = 0; k < `RX_LANES; k++) begin
            for (int j = 0; j < `BLK_W; j++) begin
                bit_s = p[k][j];
                if (scr_on) begin
                    bit_s = bit_s ^ scr_hist[`SCR_TAP_A] ^ scr_hist[`SCR_TAP_B];
                end
                scr_hist  = {scr_hist[56:0], bit_s};
                raw[k][j] = bit_s;
            end
        end
        step();
        rx_valid_i = 1'b1;
        for (int k = 0; k < `RX_LANES; k++) begin
            rx_hdr_i[(k + rot) % `RX_LANES]  = h[k];
            rx_data_i[(k + rot) % `RX_LANES] = raw[k];
        end
        exp_valid    = 1'b1;
        exp_rxc      = c;
        exp_rxd      = x;
        model_errcnt = (model_errcnt + nerr > 255) ? 255 : model_errcnt + nerr;
    endtask

    // Block kinds 0 to 5 are data, idle, start, terminate, bad header and unknown type
    task automatic gen_block(input int kind, output logic [1:0] hdr, output logic [63:0] pay);
        pay = {$urandom, $urandom};
        hdr = `HDR_CTRL;
        case (kind)
            0:       hdr = `HDR_DATA;
            1:       pay[7:0] = `BT_IDLE;
            2:       pay[7:0] = `BT_START;
            3:       pay[7:0] = term_code($urandom_range(0, 7));
            4:       hdr = $urandom_range(0, 1) ? 2'b00 : 2'b11;
            default: pay[7:0] = 8'h55;
        endcase
    endtask

    task automatic send_kinds(input int kind0, input int kind1, input int kind2, input int kind3);
        int                     kinds [4];
        rx_pcs_pkg::lane_hdr_t  h;
        rx_pcs_pkg::lane_data_t p;
        logic [1:0]             hdr;
        logic [63:0]            pay;
        kinds = '{kind0, kind1, kind2, kind3};
        for (int k = 0; k < `RX_LANES; k++) begin
            gen_block(kinds[k], hdr, pay);
            h[k] = hdr;
            p[k] = pay;
        end
        send_word(h, p);
    endtask

    task automatic send_random(input int max_kind, input int gap_pct);
        if ($urandom_range(0, 99) < gap_pct) begin
            send_gap();
        end
        send_kinds($urandom_range(0, max_kind), $urandom_range(0, max_kind),
                   $urandom_range(0, max_kind), $urandom_range(0, max_kind));
    endtask

    //////////////////////////////
    // APB access
    //////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic slverr);
        idle_cycles(4);
        psel_i     = 1'b1;
        pwrite_i   = 1'b1;
        paddr_i    = addr;
        pwdata_i   = data;
        exp_slverr = slverr;
        step();
        penable_i = 1'b1;
        step();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] data, input logic slverr);
        idle_cycles(4);
        psel_i     = 1'b1;
        pwrite_i   = 1'b0;
        paddr_i    = addr;
        exp_rdata  = data;
        exp_slverr = slverr;
        step();
        penable_i = 1'b1;
        step();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic set_ctrl(input int r, input logic bypass);
        apb_write(`ADDR_CTRL, {29'd0, 2'(r), bypass}, 1'b0);
        rot    = r;
        scr_on = !bypass;
    endtask

    task automatic read_errcnt();
        apb_read(`ADDR_ERRCNT, 32'(model_errcnt), 1'b0);
    endtask

    task automatic clear_errcnt();
        apb_write(`ADDR_ERRCNT, $urandom, 1'b0);
        model_errcnt = 0;
    endtask

    task automatic finish_test(input string name, input int fails_before);
        tests++;
        $display("Test %s finished with %0d errors", name, fails - fails_before);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic register_access();
        int f0;
        f0 = fails;
        read_errcnt();
        apb_read(`ADDR_CTRL, 32'd0, 1'b0);
        set_ctrl(2, 1'b1);
        apb_read(`ADDR_CTRL, 32'h5, 1'b0);
        // Four errors so that a stray clear of the counter shows
        send_kinds(4, 4, 4, 4);
        // Unmapped address must leave both registers alone
        apb_write(8'h08, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h0C, 32'd0, 1'b1);
        apb_read(`ADDR_CTRL, 32'h5, 1'b0);
        read_errcnt();
        finish_test("register access", f0);
    endtask

    task automatic bypass_decoding();
        int f0;
        f0 = fails;
        set_ctrl(0, 1'b1);
        repeat (150) send_random(3, 20);
        finish_test("bypass decoding", f0);
    endtask

    task automatic descrambled_stream();
        int f0;
        f0 = fails;
        set_ctrl(0, 1'b0);
        repeat (200) send_random(3, 20);
        finish_test("descrambled stream", f0);
    endtask

    task automatic lane_rotation();
        int f0;
        f0 = fails;
        for (int r = 0; r < `RX_LANES; r++) begin
            set_ctrl(r, 1'b0);
            repeat (40) send_random(3, 10);
        end
        finish_test("lane rotation", f0);
    endtask

    task automatic error_counting();
        int f0;
        f0 = fails;
        set_ctrl(1, 1'b0);
        clear_errcnt();
        // Data and terminate behind a terminate
        send_kinds(3, 0, 3, 1);
        send_kinds(4, 5, 2, 0);
        repeat (60) send_random(5, 10);
        read_errcnt();
        // 280 errors saturate the counter at 255
        repeat (70) send_kinds(4, 4, 4, 4);
        read_errcnt();
        clear_errcnt();
        read_errcnt();
        finish_test("error counting", f0);
    endtask

    initial begin
        void'($urandom(32'h3f22));
        fails         = 0;
        tests         = 0;
        model_errcnt  = 0;
        scr_hist      = '0;
        rot           = 0;
        scr_on        = 1'b1;
        exp_valid     = 1'b0;
        exp_rxc       = '0;
        exp_rxd       = '0;
        exp_slverr    = 1'b0;
        exp_rdata     = 32'd0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = 8'd0;
        pwdata_i      = 32'd0;
        rx_valid_i    = 1'b0;
        rx_hdr_i      = '0;
        rx_data_i     = '0;
        async_reset_n = 1'b0;
        repeat (10) @(posedge rx_clk_161_13);
        #5;
        async_reset_n = 1'b1;

        register_access();
        bypass_decoding();
        descrambled_stream();
        lane_rotation();
        error_counting();
        idle_cycles(6);

        $display("Tests run: %0d, failed checks: %0d", tests, fails);
        if (fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rx_pcs.f
+incdir+.
rx_pcs_pkg.sv
lane_reorder.sv
lane_descrambler.sv
block_decoder.sv
rx_pcs_regs.sv
rx_pcs_top.sv
tb_rx_pcs.sv

//--- run_sim.sh
#!/bin/sh
# Build the RX PCS testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

sim_out=""
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_pcs -f rx_pcs.f \
    && sim_out="$(./obj_dir/Vtb_rx_pcs)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Verification passed" && exit 0 || exit 1
